//--- bench/cipher_model.svh
`ifndef CIPHER_MODEL_SVH
`define CIPHER_MODEL_SVH

typedef logic [cipher_pkg::key_len-1:0][7:0]   key_bytes_t;
typedef logic [cipher_pkg::grid_size-1:0][7:0] grid_bytes_t;

// ascii letters of either case and digits
function automatic logic is_symbol(input logic [7:0] c);
  logic lower;
  logic upper;
  logic digit;
  lower = (c >= "a") && (c <= "z");
  upper = (c >= "A") && (c <= "Z");
  digit = (c >= "0") && (c <= "9");
  return lower || upper || digit;
endfunction

// case ignored: letters 0..25, digits 26..35
function automatic int symbol_index(input logic [7:0] c);
  if ((c >= "a") && (c <= "z")) begin
    return int'(c - "a");
  end else if ((c >= "A") && (c <= "Z")) begin
    return int'(c - "A");
  end else if ((c >= "0") && (c <= "9")) begin
    return int'(c - "0") + 26;
  end
  return 0;
endfunction

// all alphanumeric, no byte repeated
function automatic logic key_is_valid(input key_bytes_t k);
  logic ok;
  ok = 1'b1;
  for (int i = 0; i < cipher_pkg::key_len; i++) begin
    if (!is_symbol(k[i])) begin
      ok = 1'b0;
    end
    for (int j = 0; j < i; j++) begin
      if (k[i] == k[j]) begin
        ok = 1'b0;
      end
    end
  end
  return ok;
endfunction

function automatic grid_bytes_t rows_from_key(input key_bytes_t k);
  grid_bytes_t g;
  for (int r = 0; r < cipher_pkg::grid_size; r++) begin
    g[r] = k[cipher_pkg::row_key_order[r]];
  end
  return g;
endfunction

function automatic grid_bytes_t cols_from_key(input key_bytes_t k);
  grid_bytes_t g;
  for (int c = 0; c < cipher_pkg::grid_size; c++) begin
    g[c] = k[cipher_pkg::col_key_order[c]];
  end
  return g;
endfunction

// position 0 takes the last entry, the rest move up by one
function automatic grid_bytes_t rotate_grid(input grid_bytes_t g);
  grid_bytes_t n;
  n[0] = g[cipher_pkg::grid_size-1];
  for (int k = 1; k < cipher_pkg::grid_size; k++) begin
    n[k] = g[k-1];
  end
  return n;
endfunction

// row byte high, column byte low
function automatic logic [cipher_pkg::ctxt_width-1:0] encrypt_char(
  input grid_bytes_t rows, input grid_bytes_t cols, input logic [7:0] c);
  int idx;
  idx = symbol_index(c);
  return {rows[idx / cipher_pkg::grid_size], cols[idx % cipher_pkg::grid_size]};
endfunction

function automatic logic [31:0] xorshift32(input logic [31:0] s);
  logic [31:0] x;
  x = s;
  x = x ^ (x << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  return x;
endfunction

`endif

//--- bench/tb_cipher_top.sv
`timescale 1ns/1ps

module tb_cipher_top;

  `include "cipher_model.svh"

  localparam int clk_period   = 8;
  localparam int reset_cycles = 8;
  localparam int drain_cycles = 4;
  localparam int invalid_len  = 50;
  localparam int single_count = 20;
  localparam int single_gap   = 2;
  localparam int burst_len    = 300;
  localparam int mixed_len    = 300;
  localparam int post_key_len = 150;
  localparam int reload_len   = 60;
  localparam int reset_count  = 5;

  // stimulus and reset cycles of all phases
  localparam int test_cycles = 2 * invalid_len + single_count * (1 + single_gap)
                             + burst_len + mixed_len + post_key_len + reload_len
                             + reset_count * (reset_cycles + drain_cycles + 2);
  localparam int watchdog_cycles = 2 * test_cycles;

  localparam key_bytes_t main_key   = "Q7mX2pR9kT4z";
  localparam key_bytes_t other_key  = "aB3cD5eF7gH9";
  localparam key_bytes_t dup_key    = "abcdefghijka";
  localparam key_bytes_t space_key  = "abc def12345";

  logic                              clk;
  logic                              rst_n;
  key_bytes_t                        key;
  logic                              ptxt_valid;
  logic [7:0]                        ptxt_char;
  logic [cipher_pkg::ctxt_width-1:0] ctxt_str;
  logic                              ctxt_ready;

  grid_bytes_t                       exp_rows;
  grid_bytes_t                       exp_cols;
  logic                              exp_loaded;
  logic [cipher_pkg::ctxt_width-1:0] exp_q[$];
  logic [cipher_pkg::ctxt_width-1:0] exp_ctxt;
  // accept predicted for the coming edge, and ctxt_ready due one edge later
  logic                              accept_next;
  logic                              ready_due;
  logic [31:0]                       rng_state;
  int                                value_errs;
  int                                protocol_errs;
  int                                ready_count;

  cipher_top DUT (
    .clk        (clk),
    .rst_n      (rst_n),
    .key        (key),
    .ptxt_valid (ptxt_valid),
    .ptxt_char  (ptxt_char),
    .ctxt_str   (ctxt_str),
    .ctxt_ready (ctxt_ready)
  );

  always #(clk_period / 2) clk = ~clk;

  task automatic draw_random();
    rng_state = xorshift32(rng_state);
  endtask

  function automatic logic [7:0] symbol_from_rand(input logic [31:0] r);
    int n;
    n = int'(r % 32'd62);
    if (n < 26) begin
      return 8'(n) + "a";
    end else if (n < 52) begin
      return 8'(n - 26) + "A";
    end
    return 8'(n - 52) + "0";
  endfunction

  // alphanumerics are below 0x80, flipping bit 7 leaves that set
  function automatic logic [7:0] non_symbol_from_rand(input logic [31:0] r);
    logic [7:0] c;
    c = r[15:8];
    if (is_symbol(c)) begin
      c = c ^ 8'h80;
    end
    return c;
  endfunction

  // model of the coming clock edge, from the inputs just driven
  task automatic predict_edge();
    accept_next = 1'b0;
    if (ptxt_valid && is_symbol(ptxt_char) && exp_loaded) begin
      accept_next = 1'b1;
      exp_q.push_back(encrypt_char(exp_rows, exp_cols, ptxt_char));
      exp_rows = rotate_grid(exp_rows);
      exp_cols = rotate_grid(exp_cols);
    end else if (!exp_loaded && key_is_valid(key)) begin
      exp_rows   = rows_from_key(key);
      exp_cols   = cols_from_key(key);
      exp_loaded = 1'b1;
    end
  endtask

  task automatic drive_char(input logic valid, input logic [7:0] c);
    @(posedge clk);
    #1;
    ptxt_valid = valid;
    ptxt_char  = c;
    predict_edge();
  endtask

  task automatic change_key(input key_bytes_t k);
    @(posedge clk);
    #1;
    key        = k;
    ptxt_valid = 1'b0;
    predict_edge();
  endtask

  task automatic apply_reset(input key_bytes_t k);
    repeat (drain_cycles) drive_char(1'b0, 8'h00);
    if (exp_q.size() != 0) begin
      $display("%0d expected ciphertexts never appeared before reset at %0t",
               exp_q.size(), $time);
      protocol_errs++;
      exp_q.delete();
    end
    @(posedge clk);
    #1;
    rst_n       = 1'b0;
    key         = k;
    ptxt_valid  = 1'b0;
    exp_rows    = '0;
    exp_cols    = '0;
    exp_loaded  = 1'b0;
    accept_next = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    #1;
    rst_n = 1'b1;
    // first edge after release may load the key
    predict_edge();
  endtask

  task automatic invalid_keys_test();
    int ready_before;
    apply_reset(dup_key);
    ready_before = ready_count;
    repeat (invalid_len) begin
      draw_random();
      drive_char(1'b1, symbol_from_rand(rng_state));
    end
    change_key(space_key);
    repeat (invalid_len) begin
      draw_random();
      drive_char(1'b1, symbol_from_rand(rng_state));
    end
    repeat (2) drive_char(1'b0, 8'h00);
    if (ready_count != ready_before) begin
      $display("ctxt_ready rose %0d times while only invalid keys were applied",
               ready_count - ready_before);
      protocol_errs++;
    end
  endtask

  task automatic single_chars_test();
    apply_reset(main_key);
    for (int i = 0; i < single_count; i++) begin
      draw_random();
      drive_char(1'b1, symbol_from_rand(rng_state));
      repeat (single_gap) drive_char(1'b0, 8'h00);
    end
  endtask

  // mixed case, one character every cycle
  task automatic burst_test();
    repeat (burst_len) begin
      draw_random();
      drive_char(1'b1, symbol_from_rand(rng_state));
    end
  endtask

  task automatic reject_test();
    apply_reset(main_key);
    repeat (mixed_len) begin
      draw_random();
      case (rng_state[1:0])
        2'd0: drive_char(1'b1, symbol_from_rand(rng_state));
        2'd1: drive_char(1'b1, non_symbol_from_rand(rng_state));
        2'd2: drive_char(1'b0, symbol_from_rand(rng_state));
        default: drive_char(1'b1, symbol_from_rand(rng_state));
      endcase
    end
  endtask

  task automatic key_change_test();
    apply_reset(main_key);
    repeat (4) drive_char(1'b1, "k");
    change_key(other_key);
    repeat (post_key_len) begin
      draw_random();
      drive_char(rng_state[2:0] != 3'd0, symbol_from_rand(rng_state));
    end
    // the new key takes effect only after reset
    apply_reset(other_key);
    repeat (reload_len) begin
      draw_random();
      drive_char(1'b1, symbol_from_rand(rng_state));
    end
  endtask

  always @(posedge clk) begin
    if ((rst_n === 1'b1) && (ctxt_ready !== ready_due)) begin
      $display("ERR %0t ctxt_ready expected %b got %b", $time, ready_due, ctxt_ready);
      protocol_errs++;
    end
    if (ctxt_ready === 1'b1) begin
      ready_count++;
      if (exp_q.size() == 0) begin
        $display("ctxt_ready at %0t with no accepted character pending", $time);
        protocol_errs++;
      end else begin
        exp_ctxt = exp_q.pop_front();
        if (ctxt_str !== exp_ctxt) begin
          $display("ERR %0t ctxt_str expected %h got %h", $time, exp_ctxt, ctxt_str);
          value_errs++;
        end
      end
    end
    ready_due = accept_next;
  end

  initial begin
    #(watchdog_cycles * clk_period);
    $display("timeout after %0d cycles, run did not finish", watchdog_cycles);
    $display("errors: %0d ciphertext mismatches, %0d protocol errors",
             value_errs, protocol_errs);
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial begin
    clk           = 1'b0;
    rst_n         = 1'b0;
    key           = '0;
    ptxt_valid    = 1'b0;
    ptxt_char     = 8'h00;
    exp_rows      = '0;
    exp_cols      = '0;
    exp_loaded    = 1'b0;
    exp_ctxt      = '0;
    accept_next   = 1'b0;
    ready_due     = 1'b0;
    rng_state     = 32'd57;
    value_errs    = 0;
    protocol_errs = 0;
    ready_count   = 0;

    invalid_keys_test();
    single_chars_test();
    burst_test();
    reject_test();
    key_change_test();

    repeat (drain_cycles) drive_char(1'b0, 8'h00);
    if (exp_q.size() != 0) begin
      $display("%0d expected ciphertexts never appeared at end of run", exp_q.size());
      protocol_errs++;
    end

    $display("errors: %0d ciphertext mismatches, %0d protocol errors",
             value_errs, protocol_errs);
    if ((value_errs == 0) && (protocol_errs == 0)) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

//--- logic/char_pkg.sv
package char_pkg;

  localparam int char_width = 8;

  // width of a 0..35 cipher index
  localparam int index_width = 6;

  localparam logic [char_width-1:0] upper_a = 8'h41;
  localparam logic [char_width-1:0] upper_z = 8'h5A;
  localparam logic [char_width-1:0] lower_a = 8'h61;
  localparam logic [char_width-1:0] lower_z = 8'h7A;
  localparam logic [char_width-1:0] digit_0 = 8'h30;
  localparam logic [char_width-1:0] digit_9 = 8'h39;

  // letters of either case and digits
  function automatic logic char_is_alnum(input logic [char_width-1:0] c);
    logic is_upper;
    logic is_lower;
    logic is_digit;
    is_upper = (c >= upper_a) && (c <= upper_z);
    is_lower = (c >= lower_a) && (c <= lower_z);
    is_digit = (c >= digit_0) && (c <= digit_9);
    return is_upper || is_lower || is_digit;
  endfunction

  // case folded, letters 0..25 then digits 26..35
  function automatic logic [index_width-1:0] char_index(input logic [char_width-1:0] c);
    logic [char_width-1:0] offset;
    if ((c >= upper_a) && (c <= upper_z)) begin
      offset = c - upper_a;
    end else if ((c >= lower_a) && (c <= lower_z)) begin
      offset = c - lower_a;
    end else if ((c >= digit_0) && (c <= digit_9)) begin
      offset = c - digit_0 + 8'd26;
    end else begin
      offset = '0;
    end
    return offset[index_width-1:0];
  endfunction

endpackage

//--- logic/cipher_pkg.sv
package cipher_pkg;

  // characters in a key
  localparam int key_len = 12;

  // 6x6 grid covers the 36 symbol alphabet
  localparam int grid_size = 6;

  // row or column select width
  localparam int grid_sel_width = $clog2(grid_size);

  // key positions feeding each row, row 0 first
  localparam int row_key_order [grid_size] = '{11, 1, 9, 3, 7, 5};

  // key positions feeding each column, column 0 first
  localparam int col_key_order [grid_size] = '{10, 0, 8, 2, 6, 4};

  // row byte in the upper half, column byte in the lower half
  localparam int ctxt_width = 16;

endpackage

//--- logic/cipher_top.sv
`timescale 1ns/1ps

module cipher_top (
  input  logic                                                     clk,
  input  logic                                                     rst_n,
  input  logic [cipher_pkg::key_len-1:0][char_pkg::char_width-1:0] key,
  input  logic                                                     ptxt_valid,
  input  logic [char_pkg::char_width-1:0]                          ptxt_char,
  output logic [cipher_pkg::ctxt_width-1:0]                        ctxt_str,
  output logic                                                     ctxt_ready
);

  logic key_valid;
  logic table_loaded;
  logic advance;
  logic [cipher_pkg::grid_size-1:0][char_pkg::char_width-1:0] row_bytes;
  logic [cipher_pkg::grid_size-1:0][char_pkg::char_width-1:0] col_bytes;

  key_checker u_key_checker (
    .key       (key),
    .key_valid (key_valid)
  );

  rotor_table u_rotor_table (
    .clk          (clk),
    .rst_n        (rst_n),
    .key          (key),
    .key_valid    (key_valid),
    .advance      (advance),
    .row_bytes    (row_bytes),
    .col_bytes    (col_bytes),
    .table_loaded (table_loaded)
  );

  // advance feeds back into the table
  substitution_unit u_substitution_unit (
    .clk          (clk),
    .rst_n        (rst_n),
    .ptxt_valid   (ptxt_valid),
    .ptxt_char    (ptxt_char),
    .table_loaded (table_loaded),
    .row_bytes    (row_bytes),
    .col_bytes    (col_bytes),
    .advance      (advance),
    .ctxt_str     (ctxt_str),
    .ctxt_ready   (ctxt_ready)
  );

endmodule

//--- logic/key_checker.sv
`timescale 1ns/1ps

module key_checker (
  input  logic [cipher_pkg::key_len-1:0][char_pkg::char_width-1:0] key,
  output logic                                                     key_valid
);

  logic [cipher_pkg::key_len-1:0] char_ok;
  logic [cipher_pkg::key_len-1:0] has_dup;

  // every key character must be a letter or digit
  always_comb begin
    for (int i = 0; i < cipher_pkg::key_len; i++) begin
      char_ok[i] = char_pkg::char_is_alnum(key[i]);
    end
  end

  // each position against all later ones
  always_comb begin
    for (int i = 0; i < cipher_pkg::key_len; i++) begin
      has_dup[i] = 1'b0;
      for (int j = i + 1; j < cipher_pkg::key_len; j++) begin
        if (key[i] == key[j]) begin
          has_dup[i] = 1'b1;
        end
      end
    end
  end

  assign key_valid = (&char_ok) && !(|has_dup);

endmodule

//--- logic/rotor_table.sv
`timescale 1ns/1ps

module rotor_table (
  input  logic                                                     clk,
  input  logic                                                     rst_n,
  input  logic [cipher_pkg::key_len-1:0][char_pkg::char_width-1:0] key,
  input  logic                                                     key_valid,
  input  logic                                                     advance,
  output logic [cipher_pkg::grid_size-1:0][char_pkg::char_width-1:0] row_bytes,
  output logic [cipher_pkg::grid_size-1:0][char_pkg::char_width-1:0] col_bytes,
  output logic                                                     table_loaded
);

  logic load_table;
  logic [cipher_pkg::grid_size-1:0][char_pkg::char_width-1:0] key_rows;
  logic [cipher_pkg::grid_size-1:0][char_pkg::char_width-1:0] key_cols;
  logic [cipher_pkg::grid_size-1:0][char_pkg::char_width-1:0] rot_rows;
  logic [cipher_pkg::grid_size-1:0][char_pkg::char_width-1:0] rot_cols;

  // only the first valid key after reset is taken
  assign load_table = key_valid && !table_loaded;

  // key permutation into rows and columns
  always_comb begin
    for (int k = 0; k < cipher_pkg::grid_size; k++) begin
      key_rows[k] = key[cipher_pkg::row_key_order[k]];
      key_cols[k] = key[cipher_pkg::col_key_order[k]];
    end
  end

  // rotate by one, last element wraps to position 0
  assign rot_rows = {row_bytes[cipher_pkg::grid_size-2:0],
                     row_bytes[cipher_pkg::grid_size-1]};
  assign rot_cols = {col_bytes[cipher_pkg::grid_size-2:0],
                     col_bytes[cipher_pkg::grid_size-1]};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      table_loaded <= 1'b0;
    end else if (load_table) begin
      table_loaded <= 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      row_bytes <= '0;
      col_bytes <= '0;
    end else if (load_table) begin
      row_bytes <= key_rows;
      col_bytes <= key_cols;
    end else if (advance) begin
      // advance is only raised once the table holds a key
      row_bytes <= rot_rows;
      col_bytes <= rot_cols;
    end
  end

endmodule

//--- logic/substitution_unit.sv
`timescale 1ns/1ps

module substitution_unit (
  input  logic                                                       clk,
  input  logic                                                       rst_n,
  input  logic                                                       ptxt_valid,
  input  logic [char_pkg::char_width-1:0]                            ptxt_char,
  input  logic                                                       table_loaded,
  input  logic [cipher_pkg::grid_size-1:0][char_pkg::char_width-1:0] row_bytes,
  input  logic [cipher_pkg::grid_size-1:0][char_pkg::char_width-1:0] col_bytes,
  output logic                                                       advance,
  output logic [cipher_pkg::ctxt_width-1:0]                          ctxt_str,
  output logic                                                       ctxt_ready
);

  logic                                  char_ok;
  logic [char_pkg::index_width-1:0]      char_idx;
  logic [cipher_pkg::grid_sel_width-1:0] row_sel;
  logic [cipher_pkg::grid_sel_width-1:0] col_sel;
  logic [cipher_pkg::ctxt_width-1:0]     ctxt_next;

  assign char_ok = char_pkg::char_is_alnum(ptxt_char);

  // accept and rotate on the same edge
  assign advance = ptxt_valid && char_ok && table_loaded;

  // index splits into grid row and column
  assign char_idx = char_pkg::char_index(ptxt_char);
  assign row_sel  = cipher_pkg::grid_sel_width'(char_idx / cipher_pkg::grid_size);
  assign col_sel  = cipher_pkg::grid_sel_width'(char_idx % cipher_pkg::grid_size);

  // table state before this edge's rotation
  assign ctxt_next = {row_bytes[row_sel], col_bytes[col_sel]};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ctxt_ready <= 1'b0;
    end else begin
      ctxt_ready <= advance;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ctxt_str <= '0;
    end else if (advance) begin
      ctxt_str <= ctxt_next;
    end
  end

endmodule

//--- run_sim.sh
#!/bin/sh
# build with Verilator, run, and decide the result from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module tb_cipher_top \
  -f tb.f -o sim_cipher \
  && ./obj_dir/sim_cipher | tee sim.log \
  && grep -q '^\*\*\* TEST PASSED \*\*\*$' sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

//--- tb.f
+incdir+bench
logic/char_pkg.sv
logic/cipher_pkg.sv
logic/key_checker.sv
logic/rotor_table.sv
logic/substitution_unit.sv
logic/cipher_top.sv
bench/tb_cipher_top.sv
